//--- source/mandelPkg.sv
`default_nettype none

package mandelPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed point format
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [35:0] fixT;      // 4 integer bits incl sign
  localparam int fracBits = 32;          // Fraction bits of fixT

  // Pixel pitch at zoom 0, 1/16
  localparam fixT baseStep = 36'sh0_1000_0000;

  typedef logic [4:0] zoomT;             // Step shifts right by zoom

  // Escape bound on |z|^2, 4.0
  localparam fixT escapeLimit = 36'sh4_0000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Iteration and colour
  ////////////////////////////////////////////////////////////////////////////

  localparam int maxIter = 64;           // Iteration cap
  typedef logic [6:0] iterT;             // Holds 0..maxIter
  typedef logic [2:0] colorT;            // 0 is inside the set

  localparam int procCount = 4;          // Parallel iteration engines

  ////////////////////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    procIdle,                            // Waiting for a pixel
    procIterate,                         // One z update per clock
    procHold                             // Result parked until written
  } procStateT;

  typedef enum logic [1:0] {
    genIdle,                             // Frame finished or never started
    genScan,                             // Issuing coordinates
    genDrain                             // Waiting for the last writes
  } genStateT;

endpackage

`default_nettype wire

//--- source/framePkg.sv
`default_nettype none

package framePkg;

  // Screen geometry
  localparam int screenWidth  = 64;
  localparam int screenHeight = 48;
  localparam int pixelCount   = screenWidth * screenHeight;   // 3072

  typedef logic [5:0]  xT;               // Column
  typedef logic [5:0]  yT;               // Row

  // Row-major pixel address, row * screenWidth + column
  typedef logic [11:0] addrT;

  // Render timer
  localparam int tickCycles = 50000;     // 1 ms of 50 MHz clock
  typedef logic [15:0] msT;              // Wraps after about a minute

endpackage

`default_nettype wire

//--- source/coordGenerator.sv
`timescale 1ns/1ns
`default_nettype none

module coordGenerator (
  input  wire logic            CLOCK_50,
  input  wire logic            rstN,
  input  wire logic            draw,        // One-cycle request
  input  wire mandelPkg::fixT  upperLeftX,  // Real part of pixel (0,0)
  input  wire mandelPkg::fixT  upperLeftY,  // Imaginary part of pixel (0,0)
  input  wire mandelPkg::zoomT zoom,
  input  wire logic            coordRdy,    // From balancer
  input  wire logic            pixelWrite,  // From arbiter, one per finished pixel
  output logic                 coordVal,
  output mandelPkg::fixT       coordX,
  output mandelPkg::fixT       coordY,
  output framePkg::xT          pixX,
  output framePkg::yT          pixY,
  output logic                 done,
  output logic                 started      // Accepted draw, clears the timer
);
  import mandelPkg::*;
  import framePkg::*;

  genStateT state;
  fixT      originX;                        // Real part at column 0
  fixT      step;                           // Distance between pixels
  addrT     writeCount;                     // Writes seen this frame
  logic     transfer;
  logic     lastCol;
  logic     lastRow;
  logic     lastWrite;

  assign started   = draw && (state == genIdle);   // Draws mid-frame are dropped
  assign coordVal  = (state == genScan);
  assign transfer  = coordVal && coordRdy;
  assign lastCol   = (pixX == xT'(screenWidth - 1));
  assign lastRow   = (pixY == yT'(screenHeight - 1));
  assign lastWrite = pixelWrite && (writeCount == addrT'(pixelCount - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Frame control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      state      <= genIdle;
      done       <= 1'b1;                   // Idle screen counts as finished
      writeCount <= '0;
    end else begin
      case (state)
        genIdle: begin
          if (started) begin
            state      <= genScan;
            done       <= 1'b0;
            writeCount <= '0;
          end
        end
        genScan: begin
          if (pixelWrite) writeCount <= writeCount + 1'b1;   // Early finishers
          if (transfer && lastCol && lastRow) state <= genDrain;
        end
        genDrain: begin
          if (lastWrite) begin
            state <= genIdle;
            done  <= 1'b1;                  // One cycle after final write
          end else if (pixelWrite) begin
            writeCount <= writeCount + 1'b1;
          end
        end
        default: state <= genIdle;
      endcase
    end
  end

  // Raster walk, accumulates the step instead of multiplying
  always_ff @(posedge CLOCK_50) begin
    if (started) begin
      originX <= upperLeftX;
      step    <= baseStep >>> zoom;
      coordX  <= upperLeftX;
      coordY  <= upperLeftY;
      pixX    <= '0;
      pixY    <= '0;
    end else if (transfer) begin
      if (lastCol) begin
        pixX   <= '0;
        coordX <= originX;                  // Back to left edge
        pixY   <= pixY + 1'b1;
        coordY <= coordY + step;            // Imaginary grows downward
      end else begin
        pixX   <= pixX + 1'b1;
        coordX <= coordX + step;
      end
    end
  end

  // Offer must not change while the balancer has no free processor
  property offerHeld;
    @(posedge CLOCK_50) disable iff (!rstN)
      coordVal && !coordRdy |=> coordVal && $stable(coordX) && $stable(coordY)
                                && $stable(pixX) && $stable(pixY);
  endproperty
  assert property (offerHeld) else $error("coordinate changed while stalled");

endmodule

`default_nettype wire

//--- source/loadBalancer.sv
`timescale 1ns/1ns
`default_nettype none

module loadBalancer (
  input  wire logic                          coordVal,
  input  wire mandelPkg::fixT                coordX,
  input  wire mandelPkg::fixT                coordY,
  input  wire framePkg::xT                   pixX,
  input  wire framePkg::yT                   pixY,
  input  wire logic [mandelPkg::procCount-1:0] procReady,
  output logic                               coordRdy,
  output logic [mandelPkg::procCount-1:0]    dataVal,   // One-hot accept strobe
  output mandelPkg::fixT                     dataX,
  output mandelPkg::fixT                     dataY,
  output framePkg::xT                        dataPixX,
  output framePkg::yT                        dataPixY
);
  import mandelPkg::*;

  logic [procCount-1:0] lowestReady;

  // Isolate lowest set bit, processor 0 has priority
  assign lowestReady = procReady & (~procReady + 1'b1);

  assign coordRdy = |procReady;                          // Any free engine
  assign dataVal  = coordVal ? lowestReady : '0;

  // Payload is broadcast, only the strobed engine captures it
  assign dataX    = coordX;
  assign dataY    = coordY;
  assign dataPixX = pixX;
  assign dataPixY = pixY;

  // At most one engine strobed and never a busy one
  always_comb begin
    assert #0 ($onehot0(dataVal) && ((dataVal & ~procReady) == '0))
      else $error("dataVal not one-hot on ready processors");
  end

endmodule

`default_nettype wire

//--- source/mandelbrotProcessor.sv
`timescale 1ns/1ns
`default_nettype none

module mandelbrotProcessor (
  input  wire logic            CLOCK_50,
  input  wire logic            rstN,
  input  wire logic            dataVal,     // Accept strobe from balancer
  input  wire mandelPkg::fixT  dataX,       // c real
  input  wire mandelPkg::fixT  dataY,       // c imaginary
  input  wire framePkg::xT     dataPixX,
  input  wire framePkg::yT     dataPixY,
  input  wire logic            stored,      // Arbiter wrote our result
  output logic                 procReady,
  output logic                 resultVal,
  output framePkg::addrT       resultAddr,
  output mandelPkg::colorT     resultColor
);
  import mandelPkg::*;
  import framePkg::*;

  procStateT state;
  fixT       cr;
  fixT       ci;
  fixT       zr;
  fixT       zi;
  iterT      iterCount;                     // Iterations done so far

  // Full width products, 72 bits
  logic signed [2*$bits(fixT)-1:0] prodRR;
  logic signed [2*$bits(fixT)-1:0] prodII;
  logic signed [2*$bits(fixT)-1:0] prodRI;
  logic signed [2*$bits(fixT)-1:0] sqR;
  logic signed [2*$bits(fixT)-1:0] sqI;
  logic signed [2*$bits(fixT)-1:0] magSq;
  fixT       nextR;
  fixT       nextI;
  logic      escaped;
  logic      maxed;

  assign procReady = (state == procIdle);
  assign resultVal = (state == procHold);

  ////////////////////////////////////////////////////////////////////////////
  // z <= z^2 + c datapath
  ////////////////////////////////////////////////////////////////////////////

  assign prodRR = zr * zr;
  assign prodII = zi * zi;
  assign prodRI = zr * zi;

  assign sqR   = prodRR >>> fracBits;
  assign sqI   = prodII >>> fracBits;
  assign magSq = sqR + sqI;                 // Kept wide so large |z| cannot wrap

  assign escaped = (magSq > escapeLimit);
  assign maxed   = (iterCount == iterT'(maxIter));

  // Only used while |z|^2 <= 4, so the narrowing is safe
  assign nextR = fixT'(sqR - sqI + cr);
  assign nextI = fixT'((prodRI >>> (fracBits - 1)) + ci);   // 2*zr*zi

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      state <= procIdle;
    end else begin
      case (state)
        procIdle:    if (dataVal) state <= procIterate;
        procIterate: if (maxed || escaped) state <= procHold;
        procHold:    if (stored) state <= procIdle;   // Ready next cycle
        default:     state <= procIdle;
      endcase
    end
  end

  // Iterate registers and parked result
  always_ff @(posedge CLOCK_50) begin
    if (procReady && dataVal) begin
      cr         <= dataX;
      ci         <= dataY;
      zr         <= '0;                     // z starts at origin
      zi         <= '0;
      iterCount  <= '0;
      resultAddr <= addrT'(dataPixY) * addrT'(screenWidth) + addrT'(dataPixX);
    end else if (state == procIterate) begin
      if (maxed) begin
        resultColor <= '0;                  // Inside the set
      end else if (escaped) begin
        resultColor <= colorT'(iterCount % 7) + 1'b1;   // Bands 1..7
      end else begin
        zr        <= nextR;
        zi        <= nextI;
        iterCount <= iterCount + 1'b1;
      end
    end
  end

  // Result must survive until the arbiter has taken it
  property resultHeld;
    @(posedge CLOCK_50) disable iff (!rstN)
      resultVal && !stored |=> resultVal;
  endproperty
  assert property (resultHeld) else $error("result dropped before stored");

  // Arbiter only acknowledges a pending result
  property storedOnPending;
    @(posedge CLOCK_50) disable iff (!rstN)
      stored |-> resultVal;
  endproperty
  assert property (storedOnPending) else $error("stored without a result");

endmodule

`default_nettype wire

//--- source/pixelArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module pixelArbiter (
  input  wire logic                            CLOCK_50,
  input  wire logic                            rstN,
  input  wire logic [mandelPkg::procCount-1:0] resultVal,
  input  wire framePkg::addrT                  resultAddr [mandelPkg::procCount],
  input  wire mandelPkg::colorT                resultColor [mandelPkg::procCount],
  output logic [mandelPkg::procCount-1:0]      stored,      // Pulse on write cycle
  output logic                                 pixelWrite,
  output framePkg::addrT                       pixelAddr,
  output mandelPkg::colorT                     pixelColor
);
  import mandelPkg::*;

  typedef logic [$clog2(procCount)-1:0] procIdxT;

  logic [procCount-1:0] pending;
  procIdxT              lastGrant;          // Search starts just after this
  procIdxT              grantIdx;
  procIdxT              probe;
  logic                 grantHit;

  // A result being stored this cycle is already gone
  assign pending = resultVal & ~stored;

  // Round-robin search, index wraps modulo procCount
  always_comb begin
    grantHit = 1'b0;
    grantIdx = lastGrant;
    probe    = lastGrant;
    for (int k = 1; k <= procCount; k++) begin
      probe = lastGrant + procIdxT'(k);
      if (!grantHit && pending[probe]) begin
        grantHit = 1'b1;
        grantIdx = probe;
      end
    end
  end

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      pixelWrite <= 1'b0;
      stored     <= '0;
      lastGrant  <= procIdxT'(procCount - 1);   // First search begins at 0
    end else begin
      pixelWrite <= grantHit;
      stored     <= '0;
      if (grantHit) begin
        stored[grantIdx] <= 1'b1;
        lastGrant        <= grantIdx;
      end
    end
  end

  // Write port payload
  always_ff @(posedge CLOCK_50) begin
    if (grantHit) begin
      pixelAddr  <= resultAddr[grantIdx];
      pixelColor <= resultColor[grantIdx];
    end
  end

endmodule

`default_nettype wire

//--- source/renderTimer.sv
`timescale 1ns/1ns
`default_nettype none

module renderTimer (
  input  wire logic   CLOCK_50,
  input  wire logic   rstN,
  input  wire logic   start,                // Accepted draw
  input  wire logic   done,                 // Frame finished
  output framePkg::msT renderMs
);
  import framePkg::*;

  logic [$clog2(tickCycles)-1:0] prescale;  // Clocks within current ms

  always_ff @(posedge CLOCK_50 or negedge rstN) begin
    if (!rstN) begin
      prescale <= '0;
      renderMs <= '0;
    end else if (start) begin
      prescale <= '0;                       // New frame, new count
      renderMs <= '0;
    end else if (!done) begin
      if (prescale == tickCycles - 1) begin
        prescale <= '0;
        renderMs <= renderMs + 1'b1;
      end else begin
        prescale <= prescale + 1'b1;
      end
    end
    // Frozen while done so the last frame time stays visible
  end

endmodule

`default_nettype wire

//--- source/mandelbrotRenderer.sv
`timescale 1ns/1ns
`default_nettype none

module mandelbrotRenderer (
  input  wire logic             CLOCK_50,
  input  wire logic             rstN,
  input  wire logic             draw,
  input  wire mandelPkg::fixT   upperLeftX,
  input  wire mandelPkg::fixT   upperLeftY,
  input  wire mandelPkg::zoomT  zoom,
  output logic                  pixelWrite,   // Frame buffer write strobe
  output framePkg::addrT        pixelAddr,
  output mandelPkg::colorT      pixelColor,
  output logic                  done,
  output framePkg::msT          renderMs
);
  import mandelPkg::*;
  import framePkg::*;

  // Generator to balancer
  logic coordVal;
  logic coordRdy;
  logic started;
  fixT  coordX;
  fixT  coordY;
  xT    pixX;
  yT    pixY;

  // Balancer to processors, payload shared
  logic [procCount-1:0] dataVal;
  logic [procCount-1:0] procReady;
  fixT  dataX;
  fixT  dataY;
  xT    dataPixX;
  yT    dataPixY;

  // Processors to arbiter
  logic [procCount-1:0] resultVal;
  logic [procCount-1:0] stored;
  addrT  resultAddr [procCount];
  colorT resultColor [procCount];

  coordGenerator u_coordGenerator (
    .CLOCK_50  (CLOCK_50),
    .rstN      (rstN),
    .draw      (draw),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .zoom      (zoom),
    .coordRdy  (coordRdy),
    .pixelWrite(pixelWrite),              // Completion count
    .coordVal  (coordVal),
    .coordX    (coordX),
    .coordY    (coordY),
    .pixX      (pixX),
    .pixY      (pixY),
    .done      (done),
    .started   (started)
  );

  loadBalancer u_loadBalancer (
    .coordVal (coordVal),
    .coordX   (coordX),
    .coordY   (coordY),
    .pixX     (pixX),
    .pixY     (pixY),
    .procReady(procReady),
    .coordRdy (coordRdy),
    .dataVal  (dataVal),
    .dataX    (dataX),
    .dataY    (dataY),
    .dataPixX (dataPixX),
    .dataPixY (dataPixY)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Iteration engines
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < procCount; i++) begin : procGen
    mandelbrotProcessor u_mandelbrotProcessor (
      .CLOCK_50   (CLOCK_50),
      .rstN       (rstN),
      .dataVal    (dataVal[i]),
      .dataX      (dataX),
      .dataY      (dataY),
      .dataPixX   (dataPixX),
      .dataPixY   (dataPixY),
      .stored     (stored[i]),
      .procReady  (procReady[i]),
      .resultVal  (resultVal[i]),
      .resultAddr (resultAddr[i]),
      .resultColor(resultColor[i])
    );
  end

  pixelArbiter u_pixelArbiter (
    .CLOCK_50   (CLOCK_50),
    .rstN       (rstN),
    .resultVal  (resultVal),
    .resultAddr (resultAddr),
    .resultColor(resultColor),
    .stored     (stored),
    .pixelWrite (pixelWrite),
    .pixelAddr  (pixelAddr),
    .pixelColor (pixelColor)
  );

  renderTimer u_renderTimer (
    .CLOCK_50(CLOCK_50),
    .rstN    (rstN),
    .start   (started),
    .done    (done),
    .renderMs(renderMs)
  );

endmodule

`default_nettype wire

//--- verification/rendererChecker.sv
`timescale 1ns/1ns
`default_nettype none

module rendererChecker (
  input  wire logic             CLOCK_50,
  input  wire logic             rstN,
  input  wire logic             draw,
  input  wire mandelPkg::fixT   upperLeftX,
  input  wire mandelPkg::fixT   upperLeftY,
  input  wire mandelPkg::zoomT  zoom,
  input  wire mandelPkg::colorT cornerColor,  // Hand-worked colour of pixel (0,0)
  input  wire logic             pixelWrite,
  input  wire framePkg::addrT   pixelAddr,
  input  wire mandelPkg::colorT pixelColor,
  input  wire logic             done,
  input  wire framePkg::msT     renderMs,
  output int                    errorCount,
  output int                    writeTotal,
  output int                    frameCount
);
  import mandelPkg::*;
  import framePkg::*;

  fixT   vpX;                               // Viewport latched on accepted draw
  fixT   vpY;
  fixT   step;
  colorT expCorner;
  logic  written [pixelCount];              // Address already seen this frame
  int    frameWrites;
  int    cycle;
  int    drawCycle;
  int    lastWriteCycle;
  logic  prevDone;
  logic  drawSeen;                          // Draw accepted on the previous edge
  logic  resetChecked;

  ////////////////////////////////////////////////////////////////////////////
  // Escape-time reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic colorT refColor(fixT cx, fixT cy);
    fixT                zr;
    fixT                zi;
    logic signed [71:0] wr;
    logic signed [71:0] wi;
    logic signed [71:0] sqR;
    logic signed [71:0] sqI;
    logic signed [71:0] twoRI;
    zr = '0;
    zi = '0;
    for (int n = 0; n < maxIter; n++) begin
      wr  = zr;                             // Sign extend to product width
      wi  = zi;
      sqR = (wr * wr) >>> fracBits;
      sqI = (wi * wi) >>> fracBits;
      if (sqR + sqI > escapeLimit) return colorT'(n % 7 + 1);
      twoRI = (2 * wr * wi) >>> fracBits;
      zr    = fixT'(sqR - sqI + cx);
      zi    = fixT'(twoRI + cy);
    end
    return '0;                              // Never escaped
  endfunction

  always @(posedge CLOCK_50) begin : sampleBlock
    int    col;
    int    row;
    int    expMs;
    colorT expColor;
    if (!rstN) begin
      errorCount   = 0;
      writeTotal   = 0;
      frameCount   = 0;
      frameWrites  = 0;
      cycle        = 0;
      prevDone     = 1'b1;
      drawSeen     = 1'b0;
      resetChecked = 1'b0;
    end else begin
      cycle++;
      if (!resetChecked) begin
        resetChecked = 1'b1;
        if (pixelWrite || !done || renderMs != 0) begin
          $display("MISMATCH at %0t ns: after reset write=%b done=%b renderMs=%0d",
                   $time, pixelWrite, done, renderMs);
          errorCount++;
        end
      end
      if (drawSeen && done) begin
        $display("At %0t ns done stayed high after an accepted draw", $time);
        errorCount++;
      end
      if (prevDone && !done && !drawSeen) begin
        $display("At %0t ns done fell although no draw was accepted", $time);
        errorCount++;
      end
      if (!prevDone && done) begin          // Frame just finished
        frameCount++;
        expMs = (cycle - drawCycle) / tickCycles;
        if (frameWrites != pixelCount) begin
          $display("MISMATCH at %0t ns: frame wrote %0d pixels, expected %0d",
                   $time, frameWrites, pixelCount);
          errorCount++;
        end
        if (lastWriteCycle != cycle - 1) begin
          $display("At %0t ns done did not rise one cycle after the last write", $time);
          errorCount++;
        end
        if (int'(renderMs) + 1 < expMs || int'(renderMs) > expMs + 1) begin
          $display("MISMATCH at %0t ns: renderMs %0d, expected about %0d",
                   $time, renderMs, expMs);
          errorCount++;
        end
      end
      if (pixelWrite) begin
        if (done) begin
          $display("At %0t ns a pixel was written while done was high", $time);
          errorCount++;
        end else begin
          writeTotal++;
          frameWrites++;
          lastWriteCycle = cycle;
          if (pixelAddr >= pixelCount) begin
            $display("At %0t ns write to address %0d outside the screen", $time, pixelAddr);
            errorCount++;
          end else if (written[pixelAddr]) begin
            $display("At %0t ns address %0d was written twice", $time, pixelAddr);
            errorCount++;
          end else begin
            written[pixelAddr] = 1'b1;
            col      = pixelAddr % screenWidth;
            row      = pixelAddr / screenWidth;
            expColor = refColor(fixT'(vpX + step * col), fixT'(vpY + step * row));
            if (pixelColor != expColor) begin
              $display("MISMATCH at %0t ns: pixel (%0d,%0d) colour %0d, expected %0d",
                       $time, col, row, pixelColor, expColor);
              errorCount++;
            end
            if (pixelAddr == 0 && pixelColor != expCorner) begin
              $display("MISMATCH at %0t ns: corner colour %0d, table says %0d",
                       $time, pixelColor, expCorner);
              errorCount++;
            end
          end
        end
      end
      drawSeen = draw && done;              // Mid-frame draws are ignored
      if (drawSeen) begin
        vpX         = upperLeftX;
        vpY         = upperLeftY;
        step        = baseStep >>> zoom;
        expCorner   = cornerColor;
        drawCycle   = cycle;
        frameWrites = 0;
        foreach (written[i]) written[i] = 1'b0;
      end
      prevDone = done;
    end
  end

endmodule

`default_nettype wire

//--- verification/rendererTb.sv
`timescale 1ns/1ns
`default_nettype none

module rendererTb;
  import mandelPkg::*;
  import framePkg::*;

  localparam int rowCount = 3;
  // Every pixel at maxIter in the worst case and doubled for margin
  localparam int timeoutCycles =
    rowCount * (pixelCount * maxIter / procCount + pixelCount) * 2;

  ////////////////////////////////////////////////////////////////////////////
  // Viewport table
  ////////////////////////////////////////////////////////////////////////////

  // Full view then the boundary near -0.75 then deep inside the cardioid
  fixT   viewX [rowCount]      = '{-36'sh2_8000_0000, -36'sh1_0000_0000, -36'sh0_4000_0000};
  fixT   viewY [rowCount]      = '{-36'sh1_8000_0000, 36'sh0, -36'sh0_0400_0000};
  zoomT  viewZoom [rowCount]   = '{5'd0, 5'd3, 5'd6};
  colorT viewCorner [rowCount] = '{3'd2, 3'd0, 3'd0};  // c=(-2.5,-1.5) escapes at n=1
  logic  midDraw [rowCount]    = '{1'b0, 1'b1, 1'b0};  // Extra draw during frame

  logic  CLOCK_50;
  logic  rstN;
  logic  draw;
  fixT   upperLeftX;
  fixT   upperLeftY;
  zoomT  zoom;
  colorT cornerColor;
  logic  pixelWrite;
  addrT  pixelAddr;
  colorT pixelColor;
  logic  done;
  msT    renderMs;
  int    errorCount;
  int    writeTotal;
  int    frameCount;
  int    cycleCount = 0;

  mandelbrotRenderer u_mandelbrotRenderer (
    .CLOCK_50  (CLOCK_50),
    .rstN      (rstN),
    .draw      (draw),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .zoom      (zoom),
    .pixelWrite(pixelWrite),
    .pixelAddr (pixelAddr),
    .pixelColor(pixelColor),
    .done      (done),
    .renderMs  (renderMs)
  );

  rendererChecker u_rendererChecker (
    .CLOCK_50   (CLOCK_50),
    .rstN       (rstN),
    .draw       (draw),
    .upperLeftX (upperLeftX),
    .upperLeftY (upperLeftY),
    .zoom       (zoom),
    .cornerColor(cornerColor),
    .pixelWrite (pixelWrite),
    .pixelAddr  (pixelAddr),
    .pixelColor (pixelColor),
    .done       (done),
    .renderMs   (renderMs),
    .errorCount (errorCount),
    .writeTotal (writeTotal),
    .frameCount (frameCount)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #2 CLOCK_50 = ~CLOCK_50;        // 4 ns period
  end

  // Run limit
  always @(posedge CLOCK_50) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Run timed out after %0d cycles waiting for the renderer", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int gap;
    int failures;
    void'($urandom(32'h85797400));
    rstN        = 1'b0;
    draw        = 1'b0;
    upperLeftX  = '0;
    upperLeftY  = '0;
    zoom        = '0;
    cornerColor = '0;
    repeat (5) @(posedge CLOCK_50);
    rstN <= 1'b1;
    for (int r = 0; r < rowCount; r++) begin
      gap = $urandom % 16 + 2;              // Idle time between frames
      repeat (gap) @(posedge CLOCK_50);
      upperLeftX  <= viewX[r];
      upperLeftY  <= viewY[r];
      zoom        <= viewZoom[r];
      cornerColor <= viewCorner[r];
      draw        <= 1'b1;
      @(posedge CLOCK_50);
      draw <= 1'b0;
      do @(posedge CLOCK_50); while (done);
      if (midDraw[r]) begin
        repeat (gap) @(posedge CLOCK_50);
        upperLeftX <= viewX[(r + 1) % rowCount];   // Would spoil colours on restart
        zoom       <= viewZoom[r] + 1'b1;
        draw       <= 1'b1;
        @(posedge CLOCK_50);
        draw <= 1'b0;
      end
      while (!done) @(posedge CLOCK_50);
    end
    repeat (3) @(posedge CLOCK_50);         // Let the checker see the last edge
    failures = errorCount;
    if (frameCount != rowCount) begin
      $display("Only %0d of %0d frames completed", frameCount, rowCount);
      failures++;
    end
    $display("Frames %0d, writes %0d, errors %0d", frameCount, writeTotal, failures);
    if (failures == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mandelbrotRenderer.f
source/mandelPkg.sv
source/framePkg.sv
source/coordGenerator.sv
source/loadBalancer.sv
source/mandelbrotProcessor.sv
source/pixelArbiter.sv
source/renderTimer.sv
source/mandelbrotRenderer.sv
verification/rendererChecker.sv
verification/rendererTb.sv
